// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FLIST     ?= decode_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== decode_stage.f ====
isa_pkg.sv
pipe_pkg.sv
pipe_latch.sv
instr_decoder.sv
hazard_unit.sv
decode_stage.sv
decode_stage_assert.sv
decode_stage_tb.sv

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import pipe_pkg::*;
#(
    parameter int pc_width = pipe_pkg::pc_width
) (
    input  logic           clock,
    input  logic           reset,
    input  fetch_packet_t  fetch_in,
    input  exec_feedback_t ex_info,
    input  logic           trap,
    output decode_packet_t decode_out,
    output logic           stall
);

    fetch_packet_t  fetch_q;
    decode_packet_t decode_next;
    logic           clear;
    logic           out_bubble;

    // a stalled instruction leaves a bubble behind for execute.
    assign out_bubble = stall | clear;

    pipe_latch #(
        .payload_t (fetch_packet_t),
        .pc_width  (pc_width)
    ) fetch_latch (
        .clock  (clock),
        .reset  (reset),
        .hold   (stall),
        .bubble (clear),
        .d      (fetch_in),
        .q      (fetch_q)
    );

    instr_decoder #(
        .pc_width (pc_width)
    ) decoder (
        .fetch  (fetch_q),
        .decode (decode_next)
    );

    hazard_unit hazards (
        .fetch   (fetch_q),
        .decode  (decode_next),
        .ex_info (ex_info),
        .trap    (trap),
        .stall   (stall),
        .clear   (clear)
    );

    pipe_latch #(
        .payload_t (decode_packet_t),
        .pc_width  (pc_width)
    ) decode_latch (
        .clock  (clock),
        .reset  (reset),
        .hold   (1'b0),
        .bubble (out_bubble),
        .d      (decode_next),
        .q      (decode_out)
    );

endmodule

// ==== decode_stage_assert.sv ====
`timescale 1ns/1ps

module decode_stage_assert
    import pipe_pkg::*;
(
    input logic           clock,
    input logic           reset,
    input logic           stall,
    input logic           clear,
    input decode_packet_t decode_out
);

    // a stall or a clear leaves a bubble in the output latch.
    assert property (@(posedge clock) disable iff (reset)
                     (stall || clear) |=> !decode_out.valid)
        else $error("decode_out valid after a stall or clear");

    assert property (@(posedge clock) reset |=> !decode_out.valid)
        else $error("decode_out valid after reset");

    assert property (@(posedge clock) disable iff (reset)
                     decode_out.exception |-> decode_out.valid)
        else $error("exception on an invalid packet");

endmodule

bind decode_stage decode_stage_assert checks (
    .clock      (clock),
    .reset      (reset),
    .stall      (stall),
    .clear      (clear),
    .decode_out (decode_out)
);

// ==== decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb
    import isa_pkg::*;
    import pipe_pkg::*;
;

    typedef struct packed {
        logic [31:0]    instr;
        logic           taken;
        exec_feedback_t ex;
        logic           trap;
        op_class_t      cls;
        alu_op_t        alu;
        logic [31:0]    imm;
        logic [4:0]     waddr;
        logic [3:0]     ecause;
        logic [3:0]     hint;
        logic           stall_row;
        logic           clear_row;
    } row_t;

    logic           clock;
    logic           reset;
    fetch_packet_t  fetch_in;
    exec_feedback_t ex_info;
    logic           trap;
    decode_packet_t decode_out;
    logic           stall;

    row_t   rows[$];
    int     errors = 0;
    integer seed = 42;
    logic   table_ready = 1'b0;

    decode_stage #(.pc_width(32)) uut (
        .clock      (clock),
        .reset      (reset),
        .fetch_in   (fetch_in),
        .ex_info    (ex_info),
        .trap       (trap),
        .decode_out (decode_out),
        .stall      (stall)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic exec_feedback_t make_ex(input logic valid, input logic load,
                                               input logic [4:0] waddr, input logic jump,
                                               input logic [31:0] target, input logic busy);
        exec_feedback_t e;
        e = '0;
        e.valid = valid;
        e.load = load;
        e.waddr = waddr;
        e.jump = jump;
        e.target = target;
        e.busy = busy;
        return e;
    endfunction

    // rden1, rden2 and wren that each operation class needs.
    function automatic logic [2:0] enables_for(input row_t r);
        case (r.cls)
            class_alu:                         return {1'b1, r.instr[6:0] == 7'b0110011, 1'b1};
            class_lui, class_auipc, class_jal: return 3'b001;
            class_jalr, class_load:            return 3'b101;
            class_branch, class_store:         return 3'b110;
            default:                           return 3'b000;
        endcase
    endfunction

    task automatic add_row(input logic [31:0] instr, input op_class_t cls, input alu_op_t alu,
                           input logic [31:0] imm, input logic [4:0] waddr,
                           input logic [3:0] ecause, input logic [3:0] hint,
                           input logic taken, input exec_feedback_t ex, input logic trp,
                           input logic stall_row, input logic clear_row);
        row_t r;
        r = '{instr, taken, ex, trp, cls, alu, imm, waddr, ecause, hint, stall_row, clear_row};
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_decode(input row_t r, input logic [31:0] pc);
        logic       exc;
        logic [2:0] en;
        exc = (r.ecause != 4'd0);
        en = enables_for(r);
        check_value("decode_out.valid", 32'd1, 32'(decode_out.valid));
        check_value("decode_out.pc", pc, decode_out.pc);
        check_value("decode_out.npc", pc + 32'd4, decode_out.npc);
        check_value("decode_out.op_class", 32'(r.cls), 32'(decode_out.op_class));
        check_value("decode_out.alu_op", 32'(r.alu), 32'(decode_out.alu_op));
        check_value("decode_out.imm", r.imm, decode_out.imm);
        check_value("decode_out.waddr", 32'(r.waddr), 32'(decode_out.waddr));
        check_value("decode_out.raddr1", 32'(r.instr[19:15]), 32'(decode_out.raddr1));
        check_value("decode_out.raddr2", 32'(r.instr[24:20]), 32'(decode_out.raddr2));
        check_value("decode_out.funct3", 32'(r.instr[14:12]), 32'(decode_out.funct3));
        check_value("decode_out.rden1_rden2_wren", 32'(en),
                    32'({decode_out.rden1, decode_out.rden2, decode_out.wren}));
        check_value("decode_out.taken", 32'(r.taken), 32'(decode_out.taken));
        check_value("decode_out.hint", 32'(r.hint), 32'(decode_out.hint));
        check_value("decode_out.exception", 32'(exc), 32'(decode_out.exception));
        check_value("decode_out.ecause", 32'(r.ecause), 32'(decode_out.ecause));
        check_value("decode_out.etval", exc ? r.instr : 32'd0, decode_out.etval);
    endtask

    // a bubble keeps only its pc.
    task automatic check_bubble(input logic [31:0] pc);
        decode_packet_t expected;
        expected = '0;
        expected.pc = pc;
        if (decode_out !== expected) begin
            $display("[ERROR] %0t decode_out expected %h got %h", $time, expected, decode_out);
            errors++;
        end
    endtask

    task automatic build_table();
        exec_feedback_t none;
        logic [31:0] v;
        none = '0;
        add_row(enc_i(12'hFFB, 5'd2, 3'd0, 5'd3, 7'b0010011), class_alu, alu_add,
                32'hFFFF_FFFB, 5'd3, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_r(7'h20, 5'd9, 5'd8, 3'd0, 5'd7, 7'b0110011), class_alu, alu_sub,
                32'd0, 5'd7, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_r(7'h20, 5'd6, 5'd5, 3'd5, 5'd4, 7'b0110011), class_alu, alu_sra,
                32'd0, 5'd4, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd16, 5'd11, 3'd2, 5'd10, 7'b0000011), class_load, alu_add,
                32'd16, 5'd10, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        // store offset -8 puts 24 in the rd field.
        add_row({7'h7F, 5'd12, 5'd13, 3'd2, 5'h18, 7'b0100011}, class_store, alu_add,
                32'hFFFF_FFF8, 5'd24, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row({7'd0, 5'd2, 5'd1, 3'd0, 5'b01100, 7'b1100011}, class_branch, alu_add,
                32'd12, 5'd12, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row({20'h12345, 5'd5, 7'b0110111}, class_lui, alu_add,
                32'h1234_5000, 5'd5, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row({20'h00001, 5'd6, 7'b0010111}, class_auipc, alu_add,
                32'h0000_1000, 5'd6, 4'd0, 4'b0000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        // jal and jalr link combinations, hint order is push pop uncond rest.
        add_row({1'b0, 10'd4, 1'b0, 8'd0, 5'd1, 7'b1101111}, class_jal, alu_add,
                32'd8, 5'd1, 4'd0, 4'b1000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row({1'b0, 10'd4, 1'b0, 8'd0, 5'd0, 7'b1101111}, class_jal, alu_add,
                32'd8, 5'd0, 4'd0, 4'b0010, 1'b1, none, 1'b0, 1'b0, 1'b0);
        add_row({1'b0, 10'd4, 1'b0, 8'd0, 5'd3, 7'b1101111}, class_jal, alu_add,
                32'd8, 5'd3, 4'd0, 4'b0001, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111), class_jalr, alu_add,
                32'd0, 5'd0, 4'd0, 4'b0100, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd0, 5'd6, 3'd0, 5'd1, 7'b1100111), class_jalr, alu_add,
                32'd0, 5'd1, 4'd0, 4'b1000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd0, 5'd1, 3'd0, 5'd1, 7'b1100111), class_jalr, alu_add,
                32'd0, 5'd1, 4'd0, 4'b1000, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd0, 5'd1, 3'd0, 5'd5, 7'b1100111), class_jalr, alu_add,
                32'd0, 5'd5, 4'd0, 4'b1100, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(enc_i(12'd0, 5'd6, 3'd0, 5'd3, 7'b1100111), class_jalr, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0001, 1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_007F, class_none, alu_add, 32'd0, 5'd0, 4'd2, 4'b0000,
                1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_0001, class_none, alu_add, 32'd0, 5'd0, 4'd2, 4'b0000,
                1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(32'h0000_0073, class_system, alu_add, 32'd0, 5'd0, 4'd11, 4'b0000,
                1'b0, none, 1'b0, 1'b0, 1'b0);
        add_row(32'h0010_0073, class_system, alu_add, 32'd0, 5'd0, 4'd3, 4'b0000,
                1'b0, none, 1'b0, 1'b0, 1'b0);
        // hazards on add x3, x4, x5.
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b0,
                make_ex(1'b0, 1'b1, 5'd4, 1'b0, 32'd0, 1'b0), 1'b0, 1'b1, 1'b0);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b0,
                make_ex(1'b0, 1'b1, 5'd5, 1'b0, 32'd0, 1'b0), 1'b0, 1'b1, 1'b0);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b0,
                make_ex(1'b0, 1'b0, 5'd0, 1'b0, 32'd0, 1'b1), 1'b0, 1'b1, 1'b0);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b0,
                make_ex(1'b1, 1'b1, 5'd4, 1'b1, 32'd0, 1'b0), 1'b0, 1'b0, 1'b1);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b1,
                make_ex(1'b1, 1'b0, 5'd0, 1'b0, 32'd0, 1'b0), 1'b0, 1'b0, 1'b1);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b1,
                make_ex(1'b1, 1'b0, 5'd0, 1'b1, 32'h999, 1'b0), 1'b0, 1'b0, 1'b1);
        add_row(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3, 7'b0110011), class_alu, alu_add,
                32'd0, 5'd3, 4'd0, 4'b0000, 1'b0, none, 1'b1, 1'b0, 1'b1);
        for (int k = 0; k < 8; k++) begin
            v = $random(seed);
            add_row(enc_i(v[21:10], v[9:5], 3'd0, v[4:0], 7'b0010011), class_alu, alu_add,
                    {{20{v[21]}}, v[21:10]}, v[4:0], 4'd0, 4'b0000, 1'b0, none,
                    1'b0, 1'b0, 1'b0);
        end
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() * 4 + 10) * 10);
        $display("timeout: the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] pc;
        row_t r;
        reset = 1'b1;
        fetch_in = '0;
        ex_info = '0;
        trap = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        // outputs right after reset.
        check_value("decode_out", 32'd0, 32'(|decode_out));
        check_value("stall", 32'd0, 32'(stall));
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            pc = 32'h100 + 32'(i * 4);
            @(posedge clock);
            #1;
            fetch_in = '{1'b1, pc, r.instr, r.taken};
            ex_info = '0;
            trap = 1'b0;
            @(posedge clock);
            #1;
            fetch_in = '0;
            ex_info = r.ex;
            trap = r.trap;
            #1;
            check_value("stall", 32'(r.stall_row), 32'(stall));
            @(posedge clock);
            #1;
            ex_info = '0;
            trap = 1'b0;
            if (r.stall_row || r.clear_row) begin
                check_bubble(pc);
            end else begin
                check_decode(r, pc);
            end
            @(posedge clock);
            #1;
            if (r.stall_row) begin
                check_decode(r, pc);
            end else if (r.clear_row) begin
                // the dropped fetch packet was all zero.
                check_bubble(32'd0);
            end
        end
        $display("%0d errors in %0d rows", errors, rows.size());
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import pipe_pkg::*;
(
    input  fetch_packet_t  fetch,
    input  decode_packet_t decode,
    input  exec_feedback_t ex_info,
    input  logic           trap,
    output logic           stall,
    output logic           clear
);

    logic mispredict;
    logic load_use;

    always_comb begin
        mispredict = 1'b0;
        if (ex_info.valid) begin
            if (ex_info.jump && !fetch.taken) begin
                mispredict = 1'b1;
            end else if (!ex_info.jump && fetch.taken) begin
                mispredict = 1'b1;
            end else if (ex_info.jump && fetch.taken && ex_info.target != fetch.pc) begin
                // right direction, wrong target.
                mispredict = 1'b1;
            end
        end
    end

    always_comb begin
        load_use = 1'b0;
        if (ex_info.load) begin
            if (decode.rden1 && decode.raddr1 == ex_info.waddr) begin
                load_use = 1'b1;
            end
            if (decode.rden2 && decode.raddr2 == ex_info.waddr) begin
                load_use = 1'b1;
            end
        end
    end

    assign clear = trap || mispredict;

    // a clear flushes the stage anyway, so it overrides the stall.
    assign stall = decode.valid && (ex_info.busy || load_use) && !clear;

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int pc_width = pipe_pkg::pc_width
) (
    input  fetch_packet_t  fetch,
    output decode_packet_t decode
);

    logic [31:0] instr;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        funct7_ok;
    logic        illegal;
    logic        is_ecall;
    logic        is_ebreak;
    logic        link_w;
    logic        link_r;

    always_comb begin
        instr = fetch.instr;
        opcode = opcode_t'(instr[6:0]);
        funct3 = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        // only sub and sra use the alternate funct7.
        funct7_ok = (instr[31:25] == 7'h00) ||
                    (instr[31:25] == 7'h20 && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
        illegal = (instr[1:0] != 2'b11);
        is_ecall = 1'b0;
        is_ebreak = 1'b0;

        decode = '0;
        decode.valid = 1'b1;
        decode.pc = fetch.pc;
        decode.npc = fetch.pc + pc_width'(4);
        decode.waddr = instr[11:7];
        decode.raddr1 = instr[19:15];
        decode.raddr2 = instr[24:20];
        decode.funct3 = funct3;
        decode.taken = fetch.taken;
        decode.alu_op = alu_add;

        case (opcode)
            op_lui: begin
                decode.op_class = class_lui;
                decode.imm = imm_u;
                decode.wren = 1'b1;
            end
            op_auipc: begin
                decode.op_class = class_auipc;
                decode.imm = imm_u;
                decode.wren = 1'b1;
            end
            op_jal: begin
                decode.op_class = class_jal;
                decode.imm = imm_j;
                decode.wren = 1'b1;
            end
            op_jalr: begin
                decode.op_class = class_jalr;
                decode.imm = imm_i;
                decode.wren = 1'b1;
                decode.rden1 = 1'b1;
                illegal = illegal || (funct3 != 3'b000);
            end
            op_branch: begin
                decode.op_class = class_branch;
                decode.imm = imm_b;
                decode.rden1 = 1'b1;
                decode.rden2 = 1'b1;
                illegal = illegal || (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            op_load: begin
                decode.op_class = class_load;
                decode.imm = imm_i;
                decode.wren = 1'b1;
                decode.rden1 = 1'b1;
                illegal = illegal || (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            op_store: begin
                decode.op_class = class_store;
                decode.imm = imm_s;
                decode.rden1 = 1'b1;
                decode.rden2 = 1'b1;
                illegal = illegal || (funct3 > 3'b010);
            end
            op_imm, op_op: begin
                decode.op_class = class_alu;
                decode.imm = (opcode == op_imm) ? imm_i : 32'd0;
                decode.wren = 1'b1;
                decode.rden1 = 1'b1;
                decode.rden2 = (opcode == op_op);
                case (funct3)
                    f3_add_sub: decode.alu_op = (opcode == op_op && instr[30]) ? alu_sub : alu_add;
                    f3_sll:     decode.alu_op = alu_sll;
                    f3_slt:     decode.alu_op = alu_slt;
                    f3_sltu:    decode.alu_op = alu_sltu;
                    f3_xor:     decode.alu_op = alu_xor;
                    f3_srl_sra: decode.alu_op = instr[30] ? alu_sra : alu_srl;
                    f3_or:      decode.alu_op = alu_or;
                    f3_and:     decode.alu_op = alu_and;
                    default:    decode.alu_op = alu_add;
                endcase
                if (opcode == op_op || funct3 == f3_sll || funct3 == f3_srl_sra) begin
                    illegal = illegal || !funct7_ok;
                end
            end
            op_system: begin
                decode.op_class = class_system;
                is_ecall = (instr[19:7] == 13'd0) && (instr[31:20] == f12_ecall);
                is_ebreak = (instr[19:7] == 13'd0) && (instr[31:20] == f12_ebreak);
                illegal = illegal || !(is_ecall || is_ebreak);
            end
            default: illegal = 1'b1;
        endcase

        // x1 and x5 act as link registers.
        link_w = (decode.waddr == 5'd1) || (decode.waddr == 5'd5);
        link_r = (decode.raddr1 == 5'd1) || (decode.raddr1 == 5'd5);
        if (decode.op_class == class_jal) begin
            decode.hint.return_push = link_w;
            decode.hint.jump_uncond = (decode.waddr == 5'd0);
            decode.hint.jump_rest = !link_w && (decode.waddr != 5'd0);
        end else if (decode.op_class == class_jalr) begin
            decode.hint.return_push = link_w;
            decode.hint.return_pop = link_r && !(link_w && decode.waddr == decode.raddr1);
            decode.hint.jump_rest = !link_w && !link_r;
        end

        if (illegal) begin
            decode.op_class = class_none;
            decode.wren = 1'b0;
            decode.rden1 = 1'b0;
            decode.rden2 = 1'b0;
            decode.hint = '0;
            decode.exception = 1'b1;
            decode.ecause = cause_illegal_instr;
            decode.etval = instr;
        end else if (is_ebreak || is_ecall) begin
            decode.exception = 1'b1;
            decode.ecause = is_ebreak ? cause_breakpoint : cause_ecall_mach;
            decode.etval = instr;
        end

        if (!fetch.valid) begin
            decode = '0;
        end
    end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    // major opcodes of the base integer set.
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011,
        op_system = 7'b1110011
    } opcode_t;

    // funct3 of the register and immediate arithmetic group.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct12 of the two environment instructions.
    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;

    typedef enum logic [3:0] {
        class_none,
        class_alu,
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_system
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [3:0] {
        cause_illegal_instr = 4'd2,
        cause_breakpoint    = 4'd3,
        cause_ecall_mach    = 4'd11
    } ecause_t;

endpackage

// ==== pipe_latch.sv ====
`timescale 1ns/1ps

module pipe_latch
    import pipe_pkg::*;
#(
    parameter type payload_t = fetch_packet_t,
    parameter int  pc_width  = pipe_pkg::pc_width
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    localparam int width = $bits(payload_t);

    // keeps only the pc, which sits right below the valid bit.
    localparam logic [width-1:0] pc_mask = {
        1'b0, {pc_width{1'b1}}, {(width - 1 - pc_width){1'b0}}
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            q <= '0;
        end else if (bubble) begin
            q <= payload_t'(d & pc_mask);
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    parameter int pc_width = 32;

    // valid has to stay the first field and pc the second.
    typedef struct packed {
        logic                valid;
        logic [pc_width-1:0] pc;
        logic [31:0]         instr;
        logic                taken;
    } fetch_packet_t;

    // hints for the return address stack.
    typedef struct packed {
        logic return_push;
        logic return_pop;
        logic jump_uncond;
        logic jump_rest;
    } return_hint_t;

    typedef struct packed {
        logic                valid;
        logic [pc_width-1:0] pc;
        logic [pc_width-1:0] npc;
        logic [31:0]         imm;
        logic [4:0]          waddr;
        logic [4:0]          raddr1;
        logic [4:0]          raddr2;
        logic                rden1;
        logic                rden2;
        logic                wren;
        op_class_t           op_class;
        alu_op_t             alu_op;
        logic [2:0]          funct3;
        return_hint_t        hint;
        logic                taken;
        logic                exception;
        ecause_t             ecause;
        logic [31:0]         etval;
    } decode_packet_t;

    // state of the instruction currently in execute.
    typedef struct packed {
        logic                valid;
        logic                load;
        logic [4:0]          waddr;
        logic                jump;
        logic [pc_width-1:0] target;
        logic                busy;
    } exec_feedback_t;

endpackage
